/* hdl/bcd_pkg.sv */
package bcd_pkg;

	////////////////////////////////////////////////////////////
	// Operand geometry.
	////////////////////////////////////////////////////////////

	// Decimal digits per operand.
	localparam int bcd_digits = 4;
	// Bits per BCD digit.
	localparam int bcd_digit_w = 4;
	// Full operand width.
	localparam int bcd_word_w = bcd_digits * bcd_digit_w;

	////////////////////////////////////////////////////////////
	// Display source codes.
	////////////////////////////////////////////////////////////

	localparam int src_w = 3;
	// Nothing shown yet, after init.
	localparam logic [src_w-1:0] src_none = 3'd0;
	localparam logic [src_w-1:0] src_a = 3'd1;
	localparam logic [src_w-1:0] src_b = 3'd2;
	// Low four digits of the sum.
	localparam logic [src_w-1:0] src_sum_ls = 3'd3;
	// Carry digit of the sum.
	localparam logic [src_w-1:0] src_sum_ms = 3'd4;

	////////////////////////////////////////////////////////////
	// Controller state codes.
	////////////////////////////////////////////////////////////

	localparam int st_w = 3;
	localparam logic [st_w-1:0] st_init = 3'd0;
	localparam logic [st_w-1:0] st_load_a = 3'd1;
	localparam logic [st_w-1:0] st_display_a = 3'd2;
	localparam logic [st_w-1:0] st_load_b = 3'd3;
	localparam logic [st_w-1:0] st_display_b = 3'd4;
	localparam logic [st_w-1:0] st_display_ls = 3'd5;
	localparam logic [st_w-1:0] st_display_ms = 3'd6;

endpackage

/* hdl/button_sync.sv */
`timescale 1ns/1ps

module button_sync (
	input  logic clock,
	input  logic rst,
	// Raw front-panel buttons, asynchronous.
	input  logic load_a_btn,
	input  logic load_b_btn,
	input  logic display_ls_btn,
	input  logic display_ms_btn,
	// One-cycle pulses to the controller.
	output logic load_a_input,
	output logic load_b_input,
	output logic display_ls_input,
	output logic display_ms_input
);

	// Bit order for all vectors: ms, ls, b, a.
	logic [3:0] btn_raw;
	logic [3:0] btn_meta;
	logic [3:0] btn_sync;
	logic [3:0] btn_prev;
	logic [3:0] btn_pulse;

	assign btn_raw = {display_ms_btn, display_ls_btn, load_b_btn, load_a_btn};

	////////////////////////////////////////////////////////////
	// Two-flop synchronizer plus edge history.
	////////////////////////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (rst) begin
			btn_meta <= '0;
			btn_sync <= '0;
			btn_prev <= '0;
		end else begin
			btn_meta <= btn_raw;
			btn_sync <= btn_meta;
			// Last synchronized level, for edge detection.
			btn_prev <= btn_sync;
		end
	end

	// Rising edge only, so a held button fires once.
	always_ff @(posedge clock) begin
		if (rst) begin
			btn_pulse <= '0;
		end else begin
			btn_pulse <= btn_sync & ~btn_prev;
		end
	end

	assign load_a_input     = btn_pulse[0];
	assign load_b_input     = btn_pulse[1];
	assign display_ls_input = btn_pulse[2];
	assign display_ms_input = btn_pulse[3];

endmodule

/* hdl/bcd_digit_adder.sv */
`timescale 1ns/1ps

module bcd_digit_adder (
	input  logic [3:0] a_digit,
	input  logic [3:0] b_digit,
	input  logic carry_in,
	output logic [3:0] sum_digit,
	output logic carry_out
);

	// Binary sum, at most 9 + 9 + 1 = 19.
	logic [4:0] raw_sum;
	// Raw sum after the decimal correction.
	logic [4:0] adj_sum;

	assign raw_sum = {1'b0, a_digit} + {1'b0, b_digit} + {4'b0, carry_in};

	always_comb begin
		if (raw_sum > 5'd9) begin
			// Skip the six unused codes 10 to 15.
			adj_sum = raw_sum + 5'd6;
			carry_out = 1'b1;
		end else begin
			adj_sum = raw_sum;
			carry_out = 1'b0;
		end
	end

	// Bit 4 of the corrected sum is the carry, already out.
	assign sum_digit = adj_sum[3:0];

endmodule

/* hdl/bcd_add_controller.sv */
`timescale 1ns/1ps

module bcd_add_controller (
	input  logic clock,
	input  logic rst,
	// Button pulses from the synchronizer.
	input  logic load_a_input,
	input  logic load_b_input,
	input  logic display_ls_input,
	input  logic display_ms_input,
	// Acknowledges back from the datapath.
	input  logic init_ack,
	input  logic load_a_ack,
	input  logic load_b_ack,
	input  logic display_a_ack,
	input  logic display_b_ack,
	input  logic display_ls_ack,
	input  logic display_ms_ack,
	// Request levels to the datapath.
	output logic init,
	output logic load_a,
	output logic load_b,
	output logic display_a,
	output logic display_b,
	output logic display_ls,
	output logic display_ms
);

	import bcd_pkg::*;

	logic [st_w-1:0] state;
	logic [st_w-1:0] state_next;
	// Target state chosen by the buttons.
	logic [st_w-1:0] btn_state;
	logic btn_any;

	////////////////////////////////////////////////////////////
	// Button priority.
	////////////////////////////////////////////////////////////

	// Display MS first, then LS, then B, then A.
	always_comb begin
		btn_any = 1'b1;
		if (display_ms_input) begin
			btn_state = st_display_ms;
		end else if (display_ls_input) begin
			btn_state = st_display_ls;
		end else if (load_b_input) begin
			btn_state = st_load_b;
		end else if (load_a_input) begin
			btn_state = st_load_a;
		end else begin
			btn_state = state;
			btn_any = 1'b0;
		end
	end

	////////////////////////////////////////////////////////////
	// Next state.
	////////////////////////////////////////////////////////////

	always_comb begin
		state_next = state;
		case (state)
			// Wait for the clear to finish, then take a button.
			st_init: begin
				if (init_ack && btn_any)
					state_next = btn_state;
			end
			// Loads fall through to their display once acknowledged.
			st_load_a: begin
				if (load_a_ack)
					state_next = st_display_a;
			end
			st_load_b: begin
				if (load_b_ack)
					state_next = st_display_b;
			end
			// Display states listen only once the display is written.
			// Earlier pulses are lost.
			st_display_a: begin
				if (display_a_ack && btn_any)
					state_next = btn_state;
			end
			st_display_b: begin
				if (display_b_ack && btn_any)
					state_next = btn_state;
			end
			st_display_ls: begin
				if (display_ls_ack && btn_any)
					state_next = btn_state;
			end
			st_display_ms: begin
				if (display_ms_ack && btn_any)
					state_next = btn_state;
			end
			// Unused code, recover.
			default: state_next = st_init;
		endcase
	end

	always_ff @(posedge clock) begin
		if (rst) begin
			state <= st_init;
		end else begin
			state <= state_next;
		end
	end

	////////////////////////////////////////////////////////////
	// Requests.
	////////////////////////////////////////////////////////////

	// Decoded from the state register only, so one-hot.
	assign init       = (state == st_init);
	assign load_a     = (state == st_load_a);
	assign load_b     = (state == st_load_b);
	assign display_a  = (state == st_display_a);
	assign display_b  = (state == st_display_b);
	assign display_ls = (state == st_display_ls);
	assign display_ms = (state == st_display_ms);

endmodule

/* hdl/bcd_add_datapath.sv */
`timescale 1ns/1ps

module bcd_add_datapath (
	input  logic clock,
	input  logic rst,
	// Requests from the controller.
	input  logic init,
	input  logic load_a,
	input  logic load_b,
	input  logic display_a,
	input  logic display_b,
	input  logic display_ls,
	input  logic display_ms,
	// Operand digits from the switch bank.
	input  logic [bcd_pkg::bcd_word_w-1:0] switches,
	// Acknowledges to the controller.
	output logic init_ack,
	output logic load_a_ack,
	output logic load_b_ack,
	output logic display_a_ack,
	output logic display_b_ack,
	output logic display_ls_ack,
	output logic display_ms_ack,
	// Display register.
	output logic [bcd_pkg::bcd_word_w-1:0] display_value,
	output logic [bcd_pkg::src_w-1:0] display_src
);

	import bcd_pkg::*;

	logic [bcd_word_w-1:0] op_a;
	logic [bcd_word_w-1:0] op_b;
	logic [bcd_word_w-1:0] sum_ls;
	logic [bcd_word_w-1:0] sum_ms;
	// Ripple carries, lowest digit first.
	logic [bcd_digits:0] carry;

	////////////////////////////////////////////////////////////
	// Adder ripple.
	////////////////////////////////////////////////////////////

	assign carry[0] = 1'b0;

	generate
		for (genvar i = 0; i < bcd_digits; i++) begin : gen_digit
			bcd_digit_adder u_digit (
				.a_digit   (op_a[i*bcd_digit_w +: bcd_digit_w]),
				.b_digit   (op_b[i*bcd_digit_w +: bcd_digit_w]),
				.carry_in  (carry[i]),
				.sum_digit (sum_ls[i*bcd_digit_w +: bcd_digit_w]),
				.carry_out (carry[i+1])
			);
		end
	endgenerate

	// Fifth digit is 0 or 1, shown in the lowest nibble.
	assign sum_ms = {{(bcd_word_w-1){1'b0}}, carry[bcd_digits]};

	////////////////////////////////////////////////////////////
	// Acknowledges and actions.
	////////////////////////////////////////////////////////////

	// Each ack is its request delayed one cycle.
	always_ff @(posedge clock) begin
		if (rst) begin
			init_ack       <= 1'b0;
			load_a_ack     <= 1'b0;
			load_b_ack     <= 1'b0;
			display_a_ack  <= 1'b0;
			display_b_ack  <= 1'b0;
			display_ls_ack <= 1'b0;
			display_ms_ack <= 1'b0;
		end else begin
			init_ack       <= init;
			load_a_ack     <= load_a;
			load_b_ack     <= load_b;
			display_a_ack  <= display_a;
			display_b_ack  <= display_b;
			display_ls_ack <= display_ls;
			display_ms_ack <= display_ms;
		end
	end

	// Actions fire on the edge that raises the ack.
	always_ff @(posedge clock) begin
		if (init && !init_ack) begin
			op_a <= '0;
			op_b <= '0;
		end else begin
			if (load_a && !load_a_ack)
				op_a <= switches;
			if (load_b && !load_b_ack)
				op_b <= switches;
		end
	end

	always_ff @(posedge clock) begin
		if (rst) begin
			display_value <= '0;
			display_src   <= src_none;
		end else if (init && !init_ack) begin
			display_value <= '0;
			display_src   <= src_none;
		end else if (display_a && !display_a_ack) begin
			display_value <= op_a;
			display_src   <= src_a;
		end else if (display_b && !display_b_ack) begin
			display_value <= op_b;
			display_src   <= src_b;
		end else if (display_ls && !display_ls_ack) begin
			display_value <= sum_ls;
			display_src   <= src_sum_ls;
		end else if (display_ms && !display_ms_ack) begin
			display_value <= sum_ms;
			display_src   <= src_sum_ms;
		end
	end

endmodule

/* hdl/bcd_adder_top.sv */
`timescale 1ns/1ps

module bcd_adder_top (
	input  logic clock,
	input  logic rst,
	// Front-panel buttons.
	input  logic load_a_btn,
	input  logic load_b_btn,
	input  logic display_ls_btn,
	input  logic display_ms_btn,
	// Four BCD digits.
	input  logic [bcd_pkg::bcd_word_w-1:0] switches,
	output logic [bcd_pkg::bcd_word_w-1:0] display_value,
	output logic [bcd_pkg::src_w-1:0] display_src
);

	// Button pulses.
	logic load_a_input;
	logic load_b_input;
	logic display_ls_input;
	logic display_ms_input;

	// Requests, controller to datapath.
	logic init;
	logic load_a;
	logic load_b;
	logic display_a;
	logic display_b;
	logic display_ls;
	logic display_ms;

	// Acknowledges, datapath to controller.
	logic init_ack;
	logic load_a_ack;
	logic load_b_ack;
	logic display_a_ack;
	logic display_b_ack;
	logic display_ls_ack;
	logic display_ms_ack;

	button_sync u_sync (
		.clock            (clock),
		.rst              (rst),
		.load_a_btn       (load_a_btn),
		.load_b_btn       (load_b_btn),
		.display_ls_btn   (display_ls_btn),
		.display_ms_btn   (display_ms_btn),
		.load_a_input     (load_a_input),
		.load_b_input     (load_b_input),
		.display_ls_input (display_ls_input),
		.display_ms_input (display_ms_input)
	);

	bcd_add_controller u_ctrl (
		.clock            (clock),
		.rst              (rst),
		.load_a_input     (load_a_input),
		.load_b_input     (load_b_input),
		.display_ls_input (display_ls_input),
		.display_ms_input (display_ms_input),
		.init_ack         (init_ack),
		.load_a_ack       (load_a_ack),
		.load_b_ack       (load_b_ack),
		.display_a_ack    (display_a_ack),
		.display_b_ack    (display_b_ack),
		.display_ls_ack   (display_ls_ack),
		.display_ms_ack   (display_ms_ack),
		.init             (init),
		.load_a           (load_a),
		.load_b           (load_b),
		.display_a        (display_a),
		.display_b        (display_b),
		.display_ls       (display_ls),
		.display_ms       (display_ms)
	);

	bcd_add_datapath u_dp (
		.clock          (clock),
		.rst            (rst),
		.init           (init),
		.load_a         (load_a),
		.load_b         (load_b),
		.display_a      (display_a),
		.display_b      (display_b),
		.display_ls     (display_ls),
		.display_ms     (display_ms),
		.switches       (switches),
		.init_ack       (init_ack),
		.load_a_ack     (load_a_ack),
		.load_b_ack     (load_b_ack),
		.display_a_ack  (display_a_ack),
		.display_b_ack  (display_b_ack),
		.display_ls_ack (display_ls_ack),
		.display_ms_ack (display_ms_ack),
		.display_value  (display_value),
		.display_src    (display_src)
	);

endmodule

/* tb/bcd_adder_properties.sv */
`timescale 1ns/1ps

module bcd_adder_properties (
	input logic clock,
	input logic rst,
	input logic [bcd_pkg::st_w-1:0] state,
	input logic init,
	input logic load_a,
	input logic load_b,
	input logic display_a,
	input logic display_b,
	input logic display_ls,
	input logic display_ms,
	input logic init_ack,
	input logic load_a_ack,
	input logic load_b_ack,
	input logic display_a_ack,
	input logic display_b_ack,
	input logic display_ls_ack,
	input logic display_ms_ack
);

	import bcd_pkg::*;

	logic [6:0] req;
	logic [6:0] ack;
	// Number of failed assertions.
	int fail_count = 0;

	// Same bit order for both vectors.
	assign req = {display_ms, display_ls, display_b, display_a, load_b, load_a, init};
	assign ack = {display_ms_ack, display_ls_ack, display_b_ack, display_a_ack,
		load_b_ack, load_a_ack, init_ack};

	// One request per state.
	a_req_onehot: assert property (@(posedge clock) disable iff (rst) $onehot(req))
		else begin
			fail_count++;
			$error("request levels are not one-hot");
		end

	// Rising ack needs its request one cycle before.
	a_ack_follows_req: assert property (@(posedge clock) disable iff (rst)
		((ack & ~$past(ack)) & ~$past(req)) == 7'd0)
		else begin
			fail_count++;
			$error("acknowledge rose without its request");
		end

	a_reset_state: assert property (@(posedge clock) rst |=> (state == st_init))
		else begin
			fail_count++;
			$error("controller not in init state after reset");
		end

endmodule

// Attach to every controller instance.
bind bcd_add_controller bcd_adder_properties u_props (.*);

/* tb/bcd_adder_checker.sv */
`timescale 1ns/1ps

module bcd_adder_checker (
	input  logic clock,
	input  logic rst,
	// Check request and expected values from the stimulus.
	input  logic strobe,
	input  logic [bcd_pkg::src_w-1:0] exp_src,
	input  logic [bcd_pkg::bcd_word_w-1:0] exp_value,
	// DUT display outputs.
	input  logic [bcd_pkg::src_w-1:0] display_src,
	input  logic [bcd_pkg::bcd_word_w-1:0] display_value,
	output int check_count,
	output int error_count
);

	////////////////////////////////////////////////////////////
	// Compare on each strobe.
	////////////////////////////////////////////////////////////

	always @(posedge clock) begin : compare
		int errs;
		errs = 0;
		if (rst) begin
			check_count <= 0;
			error_count <= 0;
		end else if (strobe) begin
			if (display_src !== exp_src) begin
				$display("MISMATCH display_src: got %h, expected %h (check %0d)",
					display_src, exp_src, check_count);
				errs++;
			end
			if (display_value !== exp_value) begin
				$display("MISMATCH display_value: got %h, expected %h (check %0d)",
					display_value, exp_value, check_count);
				errs++;
			end
			check_count <= check_count + 1;
			error_count <= error_count + errs;
		end
	end

endmodule

/* tb/tb_bcd_adder.sv */
`timescale 1ns/1ps

module tb_bcd_adder;

	import bcd_pkg::*;

	localparam int table_rows = 14;
	localparam int random_rows = 40;
	// At most 18 cycles per row, plus reset.
	localparam int watch_cycles = (table_rows + random_rows) * 20 + 8;

	// Button codes in the table.
	localparam int btn_none = 0;
	localparam int btn_load_a = 1;
	localparam int btn_load_b = 2;
	localparam int btn_ls = 3;
	localparam int btn_ms = 4;

	logic clock;
	logic rst;
	// Bit order a, b, ls, ms.
	logic [3:0] btns;
	logic [bcd_word_w-1:0] switches;
	logic [bcd_word_w-1:0] display_value;
	logic [src_w-1:0] display_src;
	logic strobe;
	logic [src_w-1:0] exp_src;
	logic [bcd_word_w-1:0] exp_value;
	int check_count;
	int error_count;
	logic [31:0] lfsr;

	// Stimulus table columns.
	int tbl_btn[$];
	logic [bcd_word_w-1:0] tbl_sw[$];
	logic [src_w-1:0] tbl_src[$];
	logic [bcd_word_w-1:0] tbl_val[$];

	always #4 clock = ~clock;

	bcd_adder_top u_dut (
		.clock          (clock),
		.rst            (rst),
		.load_a_btn     (btns[0]),
		.load_b_btn     (btns[1]),
		.display_ls_btn (btns[2]),
		.display_ms_btn (btns[3]),
		.switches       (switches),
		.display_value  (display_value),
		.display_src    (display_src)
	);

	bcd_adder_checker u_chk (
		.clock         (clock),
		.rst           (rst),
		.strobe        (strobe),
		.exp_src       (exp_src),
		.exp_value     (exp_value),
		.display_src   (display_src),
		.display_value (display_value),
		.check_count   (check_count),
		.error_count   (error_count)
	);

	////////////////////////////////////////////////////////////
	// Reference model and random digits.
	////////////////////////////////////////////////////////////

	// Taps 32, 22, 2, 1.
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function automatic int bcd_to_int(input logic [15:0] w);
		int v;
		v = 0;
		for (int i = 3; i >= 0; i--)
			v = v * 10 + int'(w[i*4 +: 4]);
		return v;
	endfunction

	// Five digits, top one is the carry.
	function automatic logic [19:0] int_to_bcd5(input int v);
		logic [19:0] w;
		int r;
		r = v;
		for (int i = 0; i < 5; i++) begin
			w[i*4 +: 4] = 4'(r % 10);
			r = r / 10;
		end
		return w;
	endfunction

	task automatic random_operand(output logic [15:0] w);
		logic [3:0] d;
		for (int i = 0; i < 4; i++) begin
			for (int j = 0; j < 4; j++) begin
				lfsr = lfsr_step(lfsr);
				d = {d[2:0], lfsr[0]};
			end
			// Fold 10..15 back onto 4..9.
			if (d > 4'd9)
				d = d - 4'd6;
			w[i*4 +: 4] = d;
		end
	endtask

	////////////////////////////////////////////////////////////
	// Row sequencing.
	////////////////////////////////////////////////////////////

	task automatic add_row(input int btn, input logic [15:0] sw,
		input logic [2:0] src, input logic [15:0] val);
		tbl_btn.push_back(btn);
		tbl_sw.push_back(sw);
		tbl_src.push_back(src);
		tbl_val.push_back(val);
	endtask

	// Press, wait for the display to move, then check.
	task automatic apply_row(input int btn, input logic [15:0] sw,
		input logic [2:0] src, input logic [15:0] val);
		logic [2:0] src0;
		logic [15:0] val0;
		int n;
		@(posedge clock);
		#1;
		switches = sw;
		exp_src = src;
		exp_value = val;
		src0 = display_src;
		val0 = display_value;
		if (btn != btn_none)
			btns = 4'(1 << (btn - 1));
		repeat (4) @(posedge clock);
		#1;
		btns = 4'b0000;
		n = 0;
		while (n < 12 && display_src == src0 && display_value == val0) begin
			@(posedge clock);
			#1;
			n++;
		end
		strobe = 1'b1;
		@(posedge clock);
		#1;
		strobe = 1'b0;
	endtask

	initial begin
		logic [15:0] a;
		logic [15:0] b;
		logic [19:0] sum;
		int assert_fails;
		clock = 1'b0;
		rst = 1'b1;
		btns = 4'b0000;
		switches = '0;
		strobe = 1'b0;
		exp_src = '0;
		exp_value = '0;
		lfsr = 32'heee8;

		// Reset state, then carries, overflow and reloads.
		add_row(btn_none, 16'h0000, src_none, 16'h0000);
		add_row(btn_load_a, 16'h0199, src_a, 16'h0199);
		add_row(btn_load_b, 16'h0001, src_b, 16'h0001);
		add_row(btn_ls, 16'h0001, src_sum_ls, 16'h0200);
		add_row(btn_ms, 16'h0001, src_sum_ms, 16'h0000);
		add_row(btn_load_a, 16'h9999, src_a, 16'h9999);
		add_row(btn_ms, 16'h9999, src_sum_ms, 16'h0001);
		add_row(btn_ls, 16'h9999, src_sum_ls, 16'h0000);
		add_row(btn_load_b, 16'h1234, src_b, 16'h1234);
		add_row(btn_ls, 16'h1234, src_sum_ls, 16'h1233);
		add_row(btn_ms, 16'h1234, src_sum_ms, 16'h0001);
		add_row(btn_load_a, 16'h0456, src_a, 16'h0456);
		add_row(btn_ls, 16'h0456, src_sum_ls, 16'h1690);
		add_row(btn_ms, 16'h0456, src_sum_ms, 16'h0000);

		repeat (8) @(posedge clock);
		#1;
		rst = 1'b0;

		for (int i = 0; i < tbl_btn.size(); i++)
			apply_row(tbl_btn[i], tbl_sw[i], tbl_src[i], tbl_val[i]);

		// Four rows per operand pair.
		for (int i = 0; i < random_rows / 4; i++) begin
			random_operand(a);
			random_operand(b);
			sum = int_to_bcd5(bcd_to_int(a) + bcd_to_int(b));
			apply_row(btn_load_a, a, src_a, a);
			apply_row(btn_load_b, b, src_b, b);
			apply_row(btn_ls, b, src_sum_ls, sum[15:0]);
			apply_row(btn_ms, b, src_sum_ms, {12'h000, sum[19:16]});
		end

		repeat (2) @(posedge clock);
		assert_fails = u_dut.u_ctrl.u_props.fail_count;
		$display("checks %0d, errors %0d, assertion failures %0d",
			check_count, error_count, assert_fails);
		if (error_count == 0 && assert_fails == 0
			&& check_count == table_rows + random_rows) begin
			$display("TEST OK");
		end else begin
			if (check_count != table_rows + random_rows)
				$display("ERROR: %0d checks ran, %0d were planned",
					check_count, table_rows + random_rows);
			$display("TEST FAILED");
		end
		$finish;
	end

	// Watchdog.
	initial begin
		#(watch_cycles * 8);
		$display("ERROR: timeout, the run did not finish within %0d cycles", watch_cycles);
		$display("TEST FAILED");
		$finish;
	end

endmodule

/* all.f */
hdl/bcd_pkg.sv
hdl/button_sync.sv
hdl/bcd_digit_adder.sv
hdl/bcd_add_controller.sv
hdl/bcd_add_datapath.sv
hdl/bcd_adder_top.sv
tb/bcd_adder_properties.sv
tb/bcd_adder_checker.sv
tb/tb_bcd_adder.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the BCD adder testbench with Verilator.
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f all.f --top-module tb_bcd_adder \
	-Mdir obj_dir -o sim_bcd_adder
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/sim_bcd_adder > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "TEST FAILED" sim.log; then
	exit 1
fi
exit 0
